// ==== cacheArrays.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module cacheArrays (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`INDEX_W-1:0] index,
	output logic [`TAG_W-1:0] tagOut0,
	output logic [`TAG_W-1:0] tagOut1,
	output cachePkg::lineStateT stateOut0,
	output cachePkg::lineStateT stateOut1,
	output cachePkg::lineDataT dataOut0,
	output cachePkg::lineDataT dataOut1,
	input wire logic wrEn,
	input wire logic wrWay,
	input wire logic [`TAG_W-1:0] wrTag,
	input wire cachePkg::lineStateT wrState,
	input wire cachePkg::lineDataT wrData,
	input wire logic lruWrEn,
	input wire logic lruWay
);
	import cachePkg::*;

	logic [`TAG_W-1:0] tags [2][`SETS];
	lineDataT lines [2][`SETS];
	logic [1:0][`SETS-1:0] validBits;
	logic [1:0][`SETS-1:0] dirtyBits;
	logic [`SETS-1:0] lruBits; // one per set, shared by both ways

	assign tagOut0 = tags[0][index];
	assign tagOut1 = tags[1][index];
	assign dataOut0 = lines[0][index];
	assign dataOut1 = lines[1][index];

	assign stateOut0 = '{valid: validBits[0][index], dirty: dirtyBits[0][index], lru: lruBits[index]};
	assign stateOut1 = '{valid: validBits[1][index], dirty: dirtyBits[1][index], lru: lruBits[index]};

	// tag and data payload
	always_ff @(posedge clk) begin
		if (wrEn) begin
			tags[wrWay][index] <= wrTag;
			lines[wrWay][index] <= wrData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			dirtyBits <= '0;
			lruBits <= '0;
		end else begin
			if (wrEn) begin
				validBits[wrWay][index] <= wrState.valid;
				dirtyBits[wrWay][index] <= wrState.dirty;
			end
			if (lruWrEn)
				lruBits[index] <= ~lruWay; // other way goes next
		end
	end

endmodule

`default_nettype wire

// ==== cacheController.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module cacheController (
	input wire logic clk,
	input wire logic reset,
	input wire logic cpuReqValid,
	input wire cachePkg::cpuReqT cpuReq,
	output logic cpuReqReady,
	output logic cpuRespValid,
	output cachePkg::cpuRespT cpuResp,
	output logic [`INDEX_W-1:0] index,
	input wire logic [`TAG_W-1:0] tagOut0,
	input wire logic [`TAG_W-1:0] tagOut1,
	input wire cachePkg::lineStateT stateOut0,
	input wire cachePkg::lineStateT stateOut1,
	input wire cachePkg::lineDataT dataOut0,
	input wire cachePkg::lineDataT dataOut1,
	output logic wrEn,
	output logic wrWay,
	output logic [`TAG_W-1:0] wrTag,
	output cachePkg::lineStateT wrState,
	output cachePkg::lineDataT wrData,
	output logic lruWrEn,
	output logic lruWay,
	output logic fillStart,
	output logic [`ADDR_W-1:0] fillAddr,
	input wire logic fillDone,
	input wire cachePkg::lineDataT fillData,
	output logic wbStart,
	output logic [`ADDR_W-1:0] wbAddr,
	output cachePkg::lineDataT wbData,
	input wire logic wbBusy
);
	import cachePkg::*;

	ctrlStateE state;
	cpuReqT req;
	logic [`TAG_W-1:0] reqTag;
	logic [`WORDSEL_W-1:0] reqWord;
	logic hit0, hit1, anyHit, hitWay;
	logic victimWay, evictWay;
	lineStateT hitState, evictState;
	logic [`TAG_W-1:0] evictTag;
	lineDataT hitLine, mergedLine;
	logic selWay; // way being flushed or filled
	logic [`WORD_W-1:0] respData;
	logic respHit;

	assign reqTag = req.addr[`ADDR_W-1 -: `TAG_W];
	assign index = req.addr[`BYTE_W+`WORDSEL_W +: `INDEX_W];
	assign reqWord = req.addr[`BYTE_W +: `WORDSEL_W];

	assign cpuReqReady = (state == ctrlIdle);
	assign cpuRespValid = (state == ctrlRespond);
	assign cpuResp = '{rdata: respData, hit: respHit};

	// ------------------------------
	// lookup and victim choice
	// ------------------------------
	always_comb begin
		hit0 = stateOut0.valid && (tagOut0 == reqTag);
		hit1 = stateOut1.valid && (tagOut1 == reqTag);
		anyHit = hit0 || hit1;
		hitWay = hit1;
		hitState = hitWay ? stateOut1 : stateOut0;
		hitLine = hitWay ? dataOut1 : dataOut0;
		// empty way first, else lru
		victimWay = !stateOut0.valid ? 1'b0 : (!stateOut1.valid ? 1'b1 : stateOut0.lru);
		evictWay = (req.op == opInvalidate) ? hitWay : victimWay;
		evictState = evictWay ? stateOut1 : stateOut0;
		evictTag = evictWay ? tagOut1 : tagOut0;
		wbData = evictWay ? dataOut1 : dataOut0;
	end

	assign fillAddr = {reqTag, index, {(`WORDSEL_W+`BYTE_W){1'b0}}};
	assign wbAddr = {evictTag, index, {(`WORDSEL_W+`BYTE_W){1'b0}}};

	always_comb begin
		mergedLine = (state == ctrlFill) ? fillData : hitLine;
		if (req.op == opWrite)
			mergedLine[reqWord] = req.wdata;
	end

	// ------------------------------
	// array writes and engine launch
	// ------------------------------
	always_comb begin
		wrEn = 1'b0;
		wrWay = selWay;
		wrTag = reqTag;
		wrData = mergedLine;
		wrState = '{valid: 1'b1, dirty: (req.op == opWrite), lru: 1'b0};
		lruWrEn = 1'b0;
		lruWay = hitWay;
		fillStart = 1'b0;
		wbStart = 1'b0;
		case (state)
			ctrlLookup: begin
				if (req.op == opInvalidate) begin
					if (anyHit && hitState.dirty) begin
						wbStart = 1'b1; // flush first
					end else if (anyHit) begin
						wrEn = 1'b1;
						wrWay = hitWay;
						wrState = '0;
					end
				end else if (anyHit) begin
					lruWrEn = 1'b1;
					wrEn = (req.op == opWrite);
					wrWay = hitWay;
				end else begin
					fillStart = 1'b1;
					wbStart = evictState.valid && evictState.dirty;
				end
			end
			ctrlFlush: begin
				if (!wbBusy) begin
					wrEn = 1'b1;
					wrState = '0;
				end
			end
			ctrlFill: begin
				if (fillDone) begin
					wrEn = 1'b1;
					lruWrEn = 1'b1;
					lruWay = selWay;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlIdle;
		end else begin
			case (state)
				ctrlIdle: begin
					if (cpuReqValid) begin
						req <= cpuReq;
						state <= ctrlLookup;
					end
				end
				ctrlLookup: begin
					respData <= hitLine[reqWord];
					respHit <= !(fillStart || wbStart);
					selWay <= evictWay;
					if (fillStart)
						state <= ctrlFill;
					else if (wbStart)
						state <= ctrlFlush;
					else
						state <= ctrlRespond;
				end
				ctrlFlush: begin
					if (!wbBusy)
						state <= ctrlRespond;
				end
				ctrlFill: begin
					if (fillDone) begin
						respData <= fillData[reqWord]; // word as it came from memory
						state <= ctrlRespond;
					end
				end
				default: state <= ctrlIdle; // respond lasts one cycle
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== cachePkg.sv ====
`default_nettype none
`include "cache_params.svh"

package cachePkg;

	// ------------------------------
	// processor side
	// ------------------------------
	typedef enum logic [1:0] {
		opRead,
		opWrite,
		opInvalidate
	} cacheOpE;

	typedef struct packed {
		cacheOpE op;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
	} cpuReqT;

	typedef struct packed {
		logic [`WORD_W-1:0] rdata;
		logic hit; // served without memory traffic
	} cpuRespT;

	// ------------------------------
	// line storage
	// ------------------------------
	typedef struct packed {
		logic valid;
		logic dirty;
		logic lru; // way to replace next
	} lineStateT;

	typedef logic [`BEATS-1:0][`WORD_W-1:0] lineDataT;

	typedef enum logic [2:0] {
		ctrlIdle,
		ctrlLookup,
		ctrlFlush,
		ctrlFill,
		ctrlRespond
	} ctrlStateE;

endpackage

`default_nettype wire

// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ------------------------------
// cache geometry
// ------------------------------
`define ADDR_W 32
`define WORD_W 32

`define INDEX_W 4 // 16 sets
`define WORDSEL_W 2 // word inside a line
`define BYTE_W 2

// whatever is left above index, word select and byte offset
`define TAG_W (`ADDR_W - `INDEX_W - `WORDSEL_W - `BYTE_W)

`define BEATS 4 // one word per memory beat
`define SETS 16

`endif

// ==== lineFill.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module lineFill (
	input wire logic clk,
	input wire logic reset,
	input wire logic fillStart,
	input wire logic [`ADDR_W-1:0] fillAddr,
	output logic fillDone,
	output cachePkg::lineDataT fillData,
	output logic beatValid,
	output memBusPkg::memReqT beat,
	input wire logic beatReady,
	output logic lineBusy,
	input wire logic respValid,
	input wire memBusPkg::memRespT resp
);
	logic [`ADDR_W-`WORDSEL_W-`BYTE_W-1:0] lineBase;
	logic [`WORDSEL_W:0] issueCnt; // top bit set once all beats are out
	logic [`WORDSEL_W-1:0] retCnt;

	assign beatValid = lineBusy && !issueCnt[`WORDSEL_W];
	assign beat = '{
		write: 1'b0,
		addr: {lineBase, issueCnt[`WORDSEL_W-1:0], {`BYTE_W{1'b0}}},
		wdata: '0
	};

	always_ff @(posedge clk) begin
		if (fillStart)
			lineBase <= fillAddr[`ADDR_W-1:`WORDSEL_W+`BYTE_W];
		if (lineBusy && respValid)
			fillData[retCnt] <= resp.rdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lineBusy <= 1'b0;
			issueCnt <= '0;
			retCnt <= '0;
			fillDone <= 1'b0;
		end else begin
			fillDone <= lineBusy && respValid && (&retCnt);
			if (fillStart) begin
				lineBusy <= 1'b1;
				issueCnt <= '0;
				retCnt <= '0;
			end else begin
				if (beatValid && beatReady)
					issueCnt <= issueCnt + 1'b1;
				if (lineBusy && respValid) begin
					retCnt <= retCnt + 1'b1;
					if (&retCnt)
						lineBusy <= 1'b0; // last word in
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== lineWriteback.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module lineWriteback (
	input wire logic clk,
	input wire logic reset,
	input wire logic wbStart,
	input wire logic [`ADDR_W-1:0] wbAddr,
	input wire cachePkg::lineDataT wbData,
	output logic wbBusy,
	output logic beatValid,
	output memBusPkg::memReqT beat,
	input wire logic beatReady
);
	import cachePkg::*;

	lineDataT lineBuf; // victim captured at start
	logic [`ADDR_W-`WORDSEL_W-`BYTE_W-1:0] lineBase;
	logic [`WORDSEL_W-1:0] beatCnt;

	assign beatValid = wbBusy;
	assign beat = '{
		write: 1'b1,
		addr: {lineBase, beatCnt, {`BYTE_W{1'b0}}},
		wdata: lineBuf[beatCnt]
	};

	always_ff @(posedge clk) begin
		if (wbStart) begin
			lineBuf <= wbData;
			lineBase <= wbAddr[`ADDR_W-1:`WORDSEL_W+`BYTE_W];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wbBusy <= 1'b0;
			beatCnt <= '0;
		end else if (wbStart) begin
			wbBusy <= 1'b1;
			beatCnt <= '0;
		end else if (wbBusy && beatReady) begin
			beatCnt <= beatCnt + 1'b1;
			if (&beatCnt)
				wbBusy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== memBusArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memBusArbiter (
	input wire logic clk,
	input wire logic reset,
	input wire logic fillValid,
	input wire memBusPkg::memReqT fillBeat,
	output logic fillReady,
	input wire logic fillBusy,
	input wire logic wbValid,
	input wire memBusPkg::memReqT wbBeat,
	output logic wbReady,
	input wire logic wbBusy,
	output logic memReqValid,
	output memBusPkg::memReqT memReq,
	input wire logic memReqReady
);
	logic held; // grant locked to one engine
	logic heldWb;
	logic grantWb, grantFill;

	// writeback wins when the bus is free
	assign grantWb = held ? heldWb : wbValid;
	assign grantFill = held ? !heldWb : (!wbValid && fillValid);

	assign memReqValid = (grantWb && wbValid) || (grantFill && fillValid);
	assign memReq = grantWb ? wbBeat : fillBeat;
	assign wbReady = grantWb && memReqReady;
	assign fillReady = grantFill && memReqReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
			heldWb <= 1'b0;
		end else if (!held) begin
			if (wbValid || fillValid) begin
				held <= 1'b1;
				heldWb <= wbValid;
			end
		end else if (heldWb ? !wbBusy : !fillBusy) begin
			held <= 1'b0; // line finished
		end
	end

endmodule

`default_nettype wire

// ==== memBusPkg.sv ====
`default_nettype none
`include "cache_params.svh"

package memBusPkg;

	// one word-wide beat on the memory bus
	typedef struct packed {
		logic write;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
	} memReqT;

	// read data, returned in request order
	typedef struct packed {
		logic [`WORD_W-1:0] rdata;
	} memRespT;

endpackage

`default_nettype wire

// ==== setAssocCache.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module setAssocCache (
	input wire logic clk,
	input wire logic reset,
	input wire logic cpuReqValid,
	input wire cachePkg::cpuReqT cpuReq,
	output logic cpuReqReady,
	output logic cpuRespValid,
	output cachePkg::cpuRespT cpuResp,
	output logic memReqValid,
	output memBusPkg::memReqT memReq,
	input wire logic memReqReady,
	input wire logic memRespValid,
	input wire memBusPkg::memRespT memResp
);
	import cachePkg::*;
	import memBusPkg::*;

	// ------------------------------
	// arrays
	// ------------------------------
	logic [`INDEX_W-1:0] index;
	logic [`TAG_W-1:0] tagOut0, tagOut1, wrTag;
	lineStateT stateOut0, stateOut1, wrState;
	lineDataT dataOut0, dataOut1, wrData;
	logic wrEn, wrWay, lruWrEn, lruWay;

	// ------------------------------
	// engines and bus
	// ------------------------------
	logic fillStart, fillDone, wbStart, wbBusy;
	logic [`ADDR_W-1:0] fillAddr, wbAddr;
	lineDataT fillData, wbData;
	logic fillValid, fillReady, fillBusy, wbValid, wbReady;
	memReqT fillBeat, wbBeat;

	cacheArrays arrays (.*);

	cacheController ctrl (.*);

	lineFill fill (
		.clk, .reset, .fillStart, .fillAddr, .fillDone, .fillData,
		.beatValid(fillValid), .beat(fillBeat), .beatReady(fillReady),
		.lineBusy(fillBusy), .respValid(memRespValid), .resp(memResp)
	);

	lineWriteback wb (
		.clk, .reset, .wbStart, .wbAddr, .wbData, .wbBusy,
		.beatValid(wbValid), .beat(wbBeat), .beatReady(wbReady)
	);

	memBusArbiter arb (
		.clk, .reset, .fillValid, .fillBeat, .fillReady, .fillBusy,
		.wbValid, .wbBeat, .wbReady, .wbBusy,
		.memReqValid, .memReq, .memReqReady
	);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
cachePkg.sv
memBusPkg.sv
cacheArrays.sv
cacheController.sv
lineFill.sv
lineWriteback.sv
memBusArbiter.sv
setAssocCache.sv
tbMemModel.sv
tbSetAssocCache.sv

// ==== tbMemModel.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module tbMemModel (
	input wire logic clk,
	input wire logic reset,
	input wire logic memReqValid,
	input wire memBusPkg::memReqT memReq,
	output logic memReqReady,
	output logic memRespValid,
	output memBusPkg::memRespT memResp
);
	import memBusPkg::*;

	logic [`WORD_W-1:0] store [logic [`ADDR_W-1:0]]; // written beats only
	logic [31:0] lfsr;
	logic [`ADDR_W-1:0] pendAddr [$];
	int pendDue [$];
	int cycle;
	int due;

	function automatic logic randBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	// unwritten words hold address ^ 32'h5a5a0000
	function automatic logic [`WORD_W-1:0] peek(input logic [`ADDR_W-1:0] addr);
		if (store.exists(addr))
			return store[addr];
		return addr ^ 32'h5a5a0000;
	endfunction

	initial begin
		lfsr = 32'h3be5f848;
		memReqReady = 1'b0;
		memRespValid = 1'b0;
		memResp = '0;
	end

	always @(posedge clk) begin
		if (reset) begin
			memReqReady <= 1'b0;
			memRespValid <= 1'b0;
			cycle = 0;
			pendAddr.delete();
			pendDue.delete();
		end else begin
			cycle = cycle + 1;
			memRespValid <= 1'b0;
			if (memReqValid && memReqReady) begin
				if (memReq.write) begin
					store[memReq.addr] = memReq.wdata;
				end else begin
					due = cycle + 1 + {randBit(), randBit()}; // 1 to 4 cycles
					if (pendDue.size() > 0 && due <= pendDue[$])
						due = pendDue[$] + 1; // keep read order
					pendAddr.push_back(memReq.addr);
					pendDue.push_back(due);
				end
			end
			if (pendDue.size() > 0 && pendDue[0] <= cycle) begin
				memRespValid <= 1'b1;
				memResp <= '{rdata: peek(pendAddr.pop_front())};
				void'(pendDue.pop_front());
			end
			memReqReady <= !(randBit() && randBit()); // stall about one cycle in four
		end
	end

endmodule

`default_nettype wire

// ==== tbSetAssocCache.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cache_params.svh"

module tbSetAssocCache;
	import cachePkg::*;
	import memBusPkg::*;

	typedef struct packed {
		cacheOpE op;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] wdata;
		logic [1:0] expHit; // 2 means either
		logic chkLine;
		logic [`ADDR_W-1:0] chkAddr; // line compared in the model memory afterwards
		logic [3:0] test;
	} rowT;

	logic clk, reset;
	logic cpuReqValid, cpuReqReady, cpuRespValid;
	cpuReqT cpuReq;
	cpuRespT cpuResp;
	logic memReqValid, memReqReady, memRespValid;
	memReqT memReq;
	memRespT memResp;

	rowT rows [$];
	logic [`WORD_W-1:0] shadow [logic [`ADDR_W-1:0]];
	logic [31:0] lfsr = 32'h3be5f848;
	int beatCount;
	int checks = 0;
	int errors = 0;
	logic timedOut = 1'b0;

	setAssocCache uut (.*);
	tbMemModel mem (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (reset)
			beatCount <= 0;
		else if (memReqValid && memReqReady)
			beatCount <= beatCount + 1;
	end

	function automatic logic randBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], randBit()};
		return v;
	endfunction

	function automatic logic [`WORD_W-1:0] expectWord(input logic [`ADDR_W-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return a ^ 32'h5a5a0000;
	endfunction

	function automatic void addRow(input cacheOpE op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [1:0] expHit, input logic chkLine,
		input logic [31:0] chkAddr, input logic [3:0] test);
		rows.push_back('{op, addr, wdata, expHit, chkLine, chkAddr, test});
	endfunction

	// ------------------------------
	// stimulus table
	// ------------------------------
	function automatic void buildTable();
		logic [1:0] t, s, w;
		cacheOpE op;
		addRow(opRead, 32'h1010, 0, 2'd0, 0, 0, 1); // cold miss
		addRow(opRead, 32'h1018, 0, 2'd1, 0, 0, 1);
		addRow(opWrite, 32'h1014, 32'hdead0001, 2'd1, 0, 0, 2);
		addRow(opRead, 32'h1014, 0, 2'd1, 0, 0, 2);
		// A, B, A, then C in set 5
		addRow(opRead, 32'h2050, 0, 2'd0, 0, 0, 3);
		addRow(opWrite, 32'h3050, 32'hbeef0003, 2'd0, 0, 0, 3);
		addRow(opRead, 32'h2050, 0, 2'd1, 0, 0, 3);
		addRow(opRead, 32'h4050, 0, 2'd0, 1, 32'h3050, 3); // evicts dirty B
		addRow(opRead, 32'h2050, 0, 2'd1, 0, 0, 3);
		addRow(opRead, 32'h3050, 0, 2'd0, 0, 0, 3);
		addRow(opWrite, 32'h5094, 32'hcafe0004, 2'd0, 0, 0, 4);
		addRow(opWrite, 32'h509c, 32'hcafe0005, 2'd1, 0, 0, 4);
		addRow(opInvalidate, 32'h5090, 0, 2'd0, 1, 32'h5090, 4);
		addRow(opRead, 32'h5094, 0, 2'd0, 0, 0, 4);
		addRow(opInvalidate, 32'h60a0, 0, 2'd1, 0, 0, 5); // never cached
		addRow(opRead, 32'h70b0, 0, 2'd0, 0, 0, 5);
		addRow(opInvalidate, 32'h70b0, 0, 2'd1, 0, 0, 5);
		addRow(opRead, 32'h70b0, 0, 2'd0, 0, 0, 5);
		// 64 words: 4 tags x 4 sets x 4 words
		for (int k = 0; k < 40; k++) begin
			op = randBit() ? opWrite : opRead;
			t = randBits(2);
			s = randBits(2);
			w = randBits(2);
			addRow(op, {22'b0, t, 2'b00, s, w, 2'b00}, randBits(32), 2'd2, 0, 0, 6);
		end
	endfunction

	task automatic checkResponse(input int i, input rowT r, input int beats);
		logic [`WORD_W-1:0] exp;
		logic [`ADDR_W-1:0] a;
		if (r.op == opRead) begin
			exp = expectWord(r.addr);
			checks++;
			if (cpuResp.rdata !== exp) begin
				$display("CHECK FAILED row %0d: cpuResp.rdata got %h expected %h",
					i, cpuResp.rdata, exp);
				errors++;
			end
		end
		if (r.op == opWrite)
			shadow[r.addr] = r.wdata;
		if (r.expHit != 2'd2) begin
			checks++;
			if (cpuResp.hit !== r.expHit[0]) begin
				$display("CHECK FAILED row %0d: cpuResp.hit got %h expected %h",
					i, cpuResp.hit, r.expHit[0]);
				errors++;
			end
		end
		checks++;
		if (cpuResp.hit !== (beats == 0)) begin
			$display("CHECK FAILED row %0d: cpuResp.hit got %h expected %h after %0d beats",
				i, cpuResp.hit, beats == 0, beats);
			errors++;
		end
		if (r.chkLine) begin
			for (int w = 0; w < `BEATS; w++) begin
				a = {r.chkAddr[31:4], 4'h0} + w * 4;
				checks++;
				if (mem.peek(a) !== expectWord(a)) begin
					$display("CHECK FAILED row %0d: model memory[%h] got %h expected %h",
						i, a, mem.peek(a), expectWord(a));
					errors++;
				end
			end
		end
	endtask

	task automatic applyRow(input int i);
		rowT r;
		int n;
		int beats0;
		r = rows[i];
		n = 0;
		@(negedge clk);
		while (!cpuReqReady && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!cpuReqReady) begin
			$display("row %0d: cpuReqReady stayed low, the cache never became idle", i);
			errors++;
			timedOut = 1'b1;
			return;
		end
		beats0 = beatCount;
		@(posedge clk);
		cpuReqValid <= 1'b1;
		cpuReq <= '{op: r.op, addr: r.addr, wdata: r.wdata};
		@(posedge clk); // accepting edge
		cpuReqValid <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!cpuRespValid && n < 500) begin
			@(negedge clk);
			n++;
		end
		if (!cpuRespValid) begin
			$display("row %0d: no response came back from the cache", i);
			errors++;
			timedOut = 1'b1;
			return;
		end
		checkResponse(i, r, beatCount - beats0);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int testRows;
		int testErrStart;
		int tests;
		clk = 1'b0;
		reset = 1'b1;
		cpuReqValid = 1'b0;
		cpuReq = '0;
		testRows = 0;
		testErrStart = 0;
		tests = 0;
		buildTable();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < rows.size() && !timedOut; i++) begin
			applyRow(i);
			testRows++;
			if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
				$display("test %0d done: %0d requests, %0d errors",
					rows[i].test, testRows, errors - testErrStart);
				tests++;
				testRows = 0;
				testErrStart = errors;
			end
		end
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
